//--- source/spi_bus_pkg.sv
package spi_bus_pkg;

    ////////////////////////////////////////////////////////////////////
    // Serial bus mode and edge events
    ////////////////////////////////////////////////////////////////////

    // Packs to the usual SPI mode number {polarity, phase}
    typedef struct packed {
        logic clock_polarity;
        logic clock_phase;
    } spi_mode_t;

    // One-cycle pulses, one per serial clock edge
    typedef struct packed {
        logic leading;
        logic trailing;
    } spi_edge_t;

endpackage

//--- source/spi_frame_pkg.sv
package spi_frame_pkg;

    ////////////////////////////////////////////////////////////////////
    // Frame layout
    ////////////////////////////////////////////////////////////////////

    localparam int FRAME_BITS = 32;

    typedef logic [14:0]           address_t;
    typedef logic [15:0]           data_t;
    typedef logic [FRAME_BITS-1:0] frame_t;

    // Field order is the order on the wire, MSB first
    typedef struct packed {
        address_t address;
        logic     read_write;   // 1 = read
        data_t    data;
    } spi_command_t;

    // Shifter sequence
    typedef enum logic [1:0] {
        S_IDLE,
        S_SELECT,
        S_SHIFT,
        S_RELEASE
    } frame_state_t;

endpackage

//--- source/spi_command_port.sv
`timescale 1ns/100ps

module spi_command_port
    import spi_bus_pkg::*;
    import spi_frame_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  logic         req,
    output logic         ack,
    input  spi_command_t command,
    input  spi_mode_t    mode,
    output logic         start,
    output spi_command_t held_command,
    output spi_mode_t    held_mode,
    input  logic         done
);

    logic active;
    logic accept;

    // New request only once the previous ack has fallen
    assign accept = req && !ack && !active;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ack       <= 1'b0;
            start     <= 1'b0;
            active    <= 1'b0;
            // Sets the resting serial clock level until the first command
            held_mode <= '0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                start     <= 1'b1;
                active    <= 1'b1;
                held_mode <= mode;
            end
            if (done) begin
                ack    <= 1'b1;
                active <= 1'b0;
            end else if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held_command <= command;
        end
    end

    ack_follows_done: assert property (
        @(posedge clock) disable iff (!reset_n) $rose(ack) |-> $past(done)
    );

endmodule

//--- source/spi_bit_clock.sv
`timescale 1ns/100ps

module spi_bit_clock
    import spi_bus_pkg::*;
#(
    parameter int CLOCK_DIVIDER_WIDTH = 16
)
(
    input  logic                           clock,
    input  logic                           reset_n,
    input  logic                           run,
    input  logic [CLOCK_DIVIDER_WIDTH-1:0] divider,
    input  spi_mode_t                      mode,
    output spi_edge_t                      edges,
    output logic                           serial_clock
);

    logic [CLOCK_DIVIDER_WIDTH-1:0] count;
    logic                           half;
    logic                           tick;

    // End of a half-period, divider+1 clocks long
    assign tick = (count == divider);

    // Away from the idle level between leading and trailing edge
    assign serial_clock = mode.clock_polarity ^ half;

    ////////////////////////////////////////////////////////////////////
    // Half-period counter and edge pulses
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= '0;
            half  <= 1'b0;
            edges <= '0;
        end else if (!run) begin
            count <= '0;
            half  <= 1'b0;
            edges <= '0;
        end else begin
            edges.leading  <= tick && !half;
            edges.trailing <= tick && half;
            if (tick) begin
                count <= '0;
                half  <= !half;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    edges_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(edges.leading && edges.trailing)
    );

endmodule

//--- source/spi_frame_shifter.sv
`timescale 1ns/100ps

module spi_frame_shifter
    import spi_bus_pkg::*;
    import spi_frame_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  logic         start,
    input  spi_command_t command,
    input  spi_mode_t    mode,
    input  spi_edge_t    edges,
    output logic         run,
    output logic         slave_select,
    output logic         master_out_slave_in,
    input  logic         master_in_slave_out,
    output data_t        read_data,
    output logic         done
);

    localparam int COUNT_WIDTH = $clog2(FRAME_BITS + 1);
    localparam logic [COUNT_WIDTH-1:0] LAST_BIT = COUNT_WIDTH'(FRAME_BITS - 1);

    frame_state_t           state;
    frame_t                 load_frame;
    frame_t                 tx_shift;
    frame_t                 rx_shift;
    data_t                  tx_data;
    logic [COUNT_WIDTH-1:0] bit_count;
    logic                   sample_edge;
    logic                   shift_edge;
    logic                   last_edge;

    // Data field goes out as zeros on a read
    assign tx_data    = command.read_write ? data_t'(0) : command.data;
    assign load_frame = {command.address, command.read_write, tx_data};

    // Phase 0 samples on leading, phase 1 on trailing
    assign sample_edge = mode.clock_phase ? edges.trailing : edges.leading;
    assign shift_edge  = mode.clock_phase ? edges.leading : edges.trailing;
    assign last_edge   = edges.trailing && (bit_count == LAST_BIT);

    // Off in the cycle of the final edge, so the bit clock stops cleanly
    assign run = (state == S_SHIFT) && !last_edge;

    ////////////////////////////////////////////////////////////////////
    // Frame sequence
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state               <= S_IDLE;
            slave_select        <= 1'b1;
            master_out_slave_in <= 1'b0;
            bit_count           <= '0;
            done                <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_SELECT;
                    end
                end
                S_SELECT: begin
                    slave_select <= 1'b0;
                    bit_count    <= '0;
                    // Phase 0 needs the first bit before the leading edge
                    if (!mode.clock_phase) begin
                        master_out_slave_in <= load_frame[FRAME_BITS-1];
                    end
                    state <= S_SHIFT;
                end
                S_SHIFT: begin
                    if (shift_edge) begin
                        master_out_slave_in <= tx_shift[FRAME_BITS-1];
                    end
                    if (edges.trailing) begin
                        bit_count <= bit_count + 1'b1;
                    end
                    if (last_edge) begin
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    slave_select        <= 1'b1;
                    master_out_slave_in <= 1'b0;
                    done                <= 1'b1;
                    state               <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (state == S_SELECT) begin
            tx_shift <= mode.clock_phase ? load_frame : {load_frame[FRAME_BITS-2:0], 1'b0};
        end else if (state == S_SHIFT) begin
            if (shift_edge) begin
                tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
            end
            if (sample_edge) begin
                rx_shift <= {rx_shift[FRAME_BITS-2:0], master_in_slave_out};
            end
        end
        // Low bits hold the data field
        if (state == S_RELEASE) begin
            read_data <= rx_shift[$bits(data_t)-1:0];
        end
    end

    select_during_run: assert property (
        @(posedge clock) disable iff (!reset_n) run |-> !slave_select
    );

    bit_count_bound: assert property (
        @(posedge clock) disable iff (!reset_n) bit_count <= COUNT_WIDTH'(FRAME_BITS)
    );

endmodule

//--- source/spi_master.sv
`timescale 1ns/100ps

module spi_master
    import spi_bus_pkg::*;
    import spi_frame_pkg::*;
#(
    parameter int CLOCK_DIVIDER_WIDTH = 16
)
(
    input  logic                           clock,
    input  logic                           reset_n,
    input  logic                           req,
    output logic                           ack,
    input  spi_command_t                   command,
    input  spi_mode_t                      mode,
    input  logic [CLOCK_DIVIDER_WIDTH-1:0] divider,
    output data_t                          read_data,
    output logic                           serial_clock,
    output logic                           slave_select,
    output logic                           master_out_slave_in,
    input  logic                           master_in_slave_out
);

    logic         start;
    logic         done;
    logic         run;
    spi_command_t held_command;
    spi_mode_t    held_mode;
    spi_edge_t    edges;

    ////////////////////////////////////////////////////////////////////
    // Host handshake, frame sequence, serial clock
    ////////////////////////////////////////////////////////////////////

    spi_command_port command_port (
        .clock        (clock),
        .reset_n      (reset_n),
        .req          (req),
        .ack          (ack),
        .command      (command),
        .mode         (mode),
        .start        (start),
        .held_command (held_command),
        .held_mode    (held_mode),
        .done         (done)
    );

    spi_frame_shifter frame_shifter (
        .clock               (clock),
        .reset_n             (reset_n),
        .start               (start),
        .command             (held_command),
        .mode                (held_mode),
        .edges               (edges),
        .run                 (run),
        .slave_select        (slave_select),
        .master_out_slave_in (master_out_slave_in),
        .master_in_slave_out (master_in_slave_out),
        .read_data           (read_data),
        .done                (done)
    );

    spi_bit_clock #(
        .CLOCK_DIVIDER_WIDTH (CLOCK_DIVIDER_WIDTH)
    ) bit_clock (
        .clock        (clock),
        .reset_n      (reset_n),
        .run          (run),
        .divider      (divider),
        .mode         (held_mode),
        .edges        (edges),
        .serial_clock (serial_clock)
    );

endmodule

//--- test/spi_clock_gen.sv
`timescale 1ns/100ps

module spi_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 8
)
(
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Released on a rising edge, like any other synchronous input
    initial begin
        reset_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

//--- test/spi_slave_model.sv
`timescale 1ns/100ps

module spi_slave_model
    import spi_bus_pkg::*;
    import spi_frame_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  spi_mode_t mode,
    input  logic      serial_clock,
    input  logic      slave_select,
    input  logic      master_out_slave_in,
    output logic      master_in_slave_out
);

    data_t      memory [16];
    frame_t     last_frame;
    int         frame_count;
    frame_t     rx_shift;
    data_t      tx_shift;
    logic [5:0] bit_count;
    logic       reply_bit;
    logic       previous_clock;
    logic       clock_moved;
    logic       leading;
    logic       sample_edge;
    logic       shift_edge;

    // SCK edges seen one system clock late, once MOSI has settled
    assign clock_moved = (serial_clock != previous_clock);
    assign leading     = clock_moved && (serial_clock != mode.clock_polarity);
    assign sample_edge = mode.clock_phase ? (clock_moved && !leading) : leading;
    assign shift_edge  = mode.clock_phase ? leading : (clock_moved && !leading);

    assign master_in_slave_out = reset_n ? reply_bit : 1'b0;

    always @(posedge clock) begin
        previous_clock <= serial_clock;
        if (!reset_n) begin
            frame_count <= 0;
            last_frame  <= '0;
            bit_count   <= '0;
            tx_shift    <= '0;
            reply_bit   <= 1'b0;
            foreach (memory[i]) begin
                memory[i] <= {4'hc, 4'(i), 4'(~i), 4'(i)};
            end
        end else if (slave_select) begin
            bit_count <= '0;
            tx_shift  <= '0;
            reply_bit <= 1'b0;
        end else if (sample_edge && bit_count < 6'd32) begin
            rx_shift  <= {rx_shift[FRAME_BITS-2:0], master_out_slave_in};
            bit_count <= bit_count + 1'b1;
            // Address and read bit are in, reply goes out in the data bits
            if (bit_count == 6'd15) begin
                tx_shift <= master_out_slave_in ? memory[rx_shift[3:0]] : '0;
            end
            if (bit_count == 6'd31) begin
                last_frame  <= {rx_shift[FRAME_BITS-2:0], master_out_slave_in};
                frame_count <= frame_count + 1;
                if (!rx_shift[15]) begin
                    memory[rx_shift[19:16]] <= {rx_shift[14:0], master_out_slave_in};
                end
            end
        end else if (shift_edge) begin
            reply_bit <= tx_shift[15];
            tx_shift  <= {tx_shift[14:0], 1'b0};
        end
    end

endmodule

//--- test/spi_master_tb.sv
`timescale 1ns/100ps

module spi_master_tb
    import spi_bus_pkg::*;
    import spi_frame_pkg::*;
();

    localparam int DIVIDER_WIDTH = 16;

    typedef struct packed {
        logic                     read;
        spi_mode_t                mode;
        logic [DIVIDER_WIDTH-1:0] divider;
        address_t                 address;
        data_t                    data;
        data_t                    expected;
    } test_t;

    logic                     clock;
    logic                     reset_n;
    logic                     req;
    logic                     ack;
    spi_command_t             command;
    spi_mode_t                mode;
    logic [DIVIDER_WIDTH-1:0] divider;
    data_t                    read_data;
    logic                     serial_clock;
    logic                     slave_select;
    logic                     mosi;
    logic                     miso;

    test_t tests[$];
    int    error_count     = 0;
    int    check_count     = 0;
    int    watchdog_cycles = 0;

    spi_clock_gen clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    spi_master #(
        .CLOCK_DIVIDER_WIDTH (DIVIDER_WIDTH)
    ) uut (
        .clock               (clock),
        .reset_n             (reset_n),
        .req                 (req),
        .ack                 (ack),
        .command             (command),
        .mode                (mode),
        .divider             (divider),
        .read_data           (read_data),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (mosi),
        .master_in_slave_out (miso)
    );

    spi_slave_model slave (
        .clock               (clock),
        .reset_n             (reset_n),
        .mode                (mode),
        .serial_clock        (serial_clock),
        .slave_select        (slave_select),
        .master_out_slave_in (mosi),
        .master_in_slave_out (miso)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(string name, logic [31:0] actual, logic [31:0] expected);
        $display("[ERROR] %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
        error_count++;
    endtask

    task automatic load_tests();
        int    fd;
        string line;
        int    op;
        int    mode_value;
        int    divider_value;
        int    address_value;
        int    data_value;
        int    expected_value;
        int    total_cycles;
        test_t test;
        total_cycles = 0;
        fd = $fopen("test/spi_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file test/spi_tests.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%d %d %d %h %h %h", op, mode_value, divider_value,
                                address_value, data_value, expected_value) == 6) begin
                        test.read     = op[0];
                        test.mode     = spi_mode_t'(mode_value[1:0]);
                        test.divider  = DIVIDER_WIDTH'(divider_value);
                        test.address  = address_t'(address_value);
                        test.data     = data_t'(data_value);
                        test.expected = data_t'(expected_value);
                        tests.push_back(test);
                        // 64 half-periods per frame plus handshake and gap
                        total_cycles += (divider_value + 1) * 70 + 40;
                    end
                end
            end
            $fclose(fd);
            // Watchdog arms on the first nonzero value
            watchdog_cycles = total_cycles + 100;
        end
    endtask

    task automatic check_idle(logic expected_clock);
        check_count += 3;
        if (ack !== 1'b0) begin
            report_mismatch("ack", 32'(ack), 32'(1'b0));
        end
        if (slave_select !== 1'b1) begin
            report_mismatch("slave_select", 32'(slave_select), 32'(1'b1));
        end
        if (serial_clock !== expected_clock) begin
            report_mismatch("serial_clock", 32'(serial_clock), 32'(expected_clock));
        end
    endtask

    task automatic check_reset();
        int errors_before;
        errors_before = error_count;
        @(posedge clock);
        while (!reset_n) begin
            @(posedge clock);
            check_idle(1'b0);
        end
        @(posedge clock);
        check_idle(1'b0);
        $display("reset: %s", (error_count == errors_before) ? "ok" : "failed");
    endtask

    //////////////////////////////////////////////////////////////////////
    // One command through the four-phase handshake
    //////////////////////////////////////////////////////////////////////

    task automatic run_test(int index);
        test_t  test;
        frame_t expected_frame;
        int     cycles;
        int     shortest;
        int     hold_cycles;
        int     frames_before;
        int     errors_before;
        test           = tests[index];
        errors_before  = error_count;
        frames_before  = slave.frame_count;
        expected_frame = {test.address, test.read, test.read ? 16'h0000 : test.data};
        shortest       = 64 * (int'(test.divider) + 1);
        hold_cycles    = $urandom_range(1, 8);
        cycles         = 0;

        @(posedge clock);
        command <= {test.address, test.read, test.data};
        mode    <= test.mode;
        divider <= test.divider;
        req     <= 1'b1;
        do begin
            @(posedge clock);
            cycles++;
        end while (!ack);

        check_count++;
        if (slave.last_frame !== expected_frame) begin
            report_mismatch("slave frame", slave.last_frame, expected_frame);
        end
        if (test.read) begin
            check_count++;
            if (read_data !== test.expected) begin
                report_mismatch("read_data", 32'(read_data), 32'(test.expected));
            end
        end
        check_count++;
        if (cycles < shortest || cycles > shortest + 16) begin
            $display("Test %0d took %0d cycles from req to ack, expected %0d to %0d",
                     index, cycles, shortest, shortest + 16);
            error_count++;
        end

        // Host keeps req high, ack must stay and no frame may start
        repeat (hold_cycles) begin
            @(posedge clock);
            check_count += 2;
            if (ack !== 1'b1) begin
                report_mismatch("ack", 32'(ack), 32'(1'b1));
            end
            if (slave_select !== 1'b1) begin
                report_mismatch("slave_select", 32'(slave_select), 32'(1'b1));
            end
        end

        req <= 1'b0;
        do begin
            @(posedge clock);
        end while (ack);
        check_idle(test.mode.clock_polarity);
        check_count++;
        if (slave.frame_count !== frames_before + 1) begin
            report_mismatch("slave frame count", 32'(slave.frame_count),
                            32'(frames_before + 1));
        end

        repeat ($urandom_range(0, 4)) @(posedge clock);
        $display("test %0d: %s mode %0d divider %0d address 0x%h, %0d cycles, %s",
                 index, test.read ? "read " : "write", test.mode, test.divider,
                 test.address, cycles, (error_count == errors_before) ? "ok" : "failed");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        req     <= 1'b0;
        command <= '0;
        mode    <= '0;
        divider <= '0;
        void'($urandom(32'hfdd3));
        load_tests();
        check_reset();
        foreach (tests[i]) begin
            run_test(i);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", tests.size(), check_count,
                 error_count);
        if (error_count == 0 && tests.size() > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Watchdog expired after %0d clock cycles, a handshake never finished",
                 watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- sim.f
source/spi_bus_pkg.sv
source/spi_frame_pkg.sv
source/spi_command_port.sv
source/spi_bit_clock.sv
source/spi_frame_shifter.sv
source/spi_master.sv
test/spi_clock_gen.sv
test/spi_slave_model.sv
test/spi_master_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SPI master testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module spi_master_tb \
    -f sim.f -Mdir obj_dir -o spi_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/spi_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log_file"; then
    echo "Simulation reported failures, see $log_file"
    exit 1
fi

echo "Simulation passed"
exit 0

//--- test/spi_tests.txt
# op (0 write, 1 read), mode, divider, then address, data, expected read value in hex
# data on a read line is still driven and must go out as zeros
0 0 1 0001 a5c3 0000
0 1 1 0012 3c5a 0000
0 2 1 7ff3 8001 0000
0 3 1 4a34 ffff 0000
1 0 1 0001 dead a5c3
1 1 0 0012 beef 3c5a
1 2 5 7ff3 0000 8001
1 3 0 4a34 1111 ffff
0 0 0 2345 1234 0000
0 3 5 0006 fedc 0000
1 1 5 2345 0000 1234
1 2 1 0006 ffff fedc
0 1 0 000f 0f0f 0000
1 0 5 000f 0000 0f0f
0 2 0 0001 5aa5 0000
1 3 1 0001 cafe 5aa5
